// File: Makefile
VERILATOR ?= verilator
TOP       ?= decodeTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc

check: run
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/clkGen.sv
`default_nettype none

module clkGen (
    output logic clk,
    output logic arstN
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod  = 5;    // 10 ns clock
    localparam int ResetCycles = 3;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule : clkGen

`default_nettype wire

// File: dv/decodeGolden.txt
// wbCtl wbData inst pc exCtl exData memCtl memData hold expOp expRdCtl expRs1 expRs2 expImm
// Ctl words use bit 12 for writeEn, bit 8 for enable or isLoad or rdEn, bits 4 to 0 for index
101 1000     123452b7 100 0    0        0    0        0 01 105 0        0        12345000
102 deadbeef fffff317 104 0    0        0    0        0 02 106 0        0        fffff000
103 7        ffdff0ef 108 0    0        0    0        0 03 101 0        0        fffffffc
0   0        008083e7 10c 0    0        0    0        0 04 107 1000     0        8
0   0        fe20ece3 110 0    0        0    0        0 09 0   1000     deadbeef fffffff8
0   0        ffc1a403 114 0    0        0    0        0 0d 108 7        0        fffffffc
0   0        0020a623 118 0    0        0    0        0 12 0   1000     deadbeef c
0   0        40415493 11c 0    0        0    0        0 1b 109 deadbeef 0        4
100 55555555 fff00513 120 0    0        0    0        0 13 10a 0        0        ffffffff
0   0        402085b3 124 1001 11111111 1001 22222222 0 1d 10b 11111111 deadbeef 0
0   0        00208633 128 1003 44444444 1002 33333333 0 1c 10c 1000     33333333 0
0   0        002006b3 12c 1000 99999999 1000 88888888 0 1c 10d 0        deadbeef 0
0   0        00508713 130 1105 77777777 1005 66666666 0 13 10e 1000     0        5
0   0        001187b3 134 1103 12121212 1003 66666666 3 1c 10f 66666666 1000     0
0   0        00312023 138 1103 abcdabcd 0    0        2 12 0   deadbeef 7        0
0   0        0000000f 13c 0    0        0    0        0 00 0   0        0        0
0   0        00000073 140 0    0        0    0        0 00 0   0        0        0
0   0        02208633 144 1101 5a5a5a5a 0    0        0 00 0   0        0        0
0   0        0020a063 148 1101 5a5a5a5a 0    0        0 00 0   0        0        0
0   0        abcde037 14c 0    0        0    0        0 01 0   0        0        abcde000

// File: dv/decodeTb.sv
`default_nettype none

module decodeTb import rvIsaPkg::*, pipePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumVecs   = 20;
    localparam int VecWords  = 14;     // Words per golden line
    localparam int WaitLimit = 40;     // Cycles before a wait gives up

    logic     clk;
    logic     arstN;
    logic     instReq;
    word_t    inst;
    word_t    pc;
    logic     instAck;
    fwdPath_t exFwd;
    fwdPath_t memFwd;
    fwdPath_t wbFwd;
    decoded_t idEx;

    word_t golden [0:NumVecs*VecWords-1];
    int    errCount;
    int    timeoutCount;
    int    acceptCount;
    int    validCount = 0;
    logic  timedOut;

    clkGen uClkGen (
        .clk   (clk),
        .arstN (arstN)
    );

    decodeStage UUT (
        .clk     (clk),
        .arstN   (arstN),
        .instReq (instReq),
        .inst    (inst),
        .pc      (pc),
        .instAck (instAck),
        .exFwd   (exFwd),
        .memFwd  (memFwd),
        .wbFwd   (wbFwd),
        .idEx    (idEx)
    );

    always @(negedge clk) begin
        if (arstN && idEx.valid)
            validCount++;    // Pulses seen by execute
    end

    task automatic reportMismatch(input string name, input word_t expected,
                                  input word_t actual);
        errCount++;
        $display("ERR %s expected %h actual %h", name, expected, actual);
    endtask

    // Control word has bit 12 writeEn, bit 8 isLoad, bits 4 to 0 index
    function automatic fwdPath_t unpackFwd(input word_t ctl, input word_t data);
        fwdPath_t path;
        path.writeEn = ctl[12];
        path.rdIdx   = ctl[4:0];
        path.data    = data;
        path.isLoad  = ctl[8];
        return path;
    endfunction

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        while (arstN !== 1'b1 && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (arstN !== 1'b1) begin
            timeoutCount++;
            timedOut = 1'b1;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic waitAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (instAck !== level && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (instAck !== level) begin
            timeoutCount++;
            timedOut = 1'b1;
            $display("Timeout: instAck never went to %b %s", level, what);
        end
    endtask

    task automatic preloadRegister(input word_t ctl, input word_t data);
        @(posedge clk);
        wbFwd <= '{writeEn: 1'b1, rdIdx: ctl[4:0], data: data, isLoad: 1'b0};
        @(posedge clk);
        wbFwd <= '0;
    endtask

    task automatic runVector(input int v);
        int    base;
        int    hold;
        word_t expRd;
        base  = v * VecWords;
        hold  = int'(golden[base+8]);
        expRd = golden[base+10];
        if (golden[base][8])
            preloadRegister(golden[base], golden[base+1]);
        @(posedge clk);
        inst    <= golden[base+2];
        pc      <= golden[base+3];
        exFwd   <= unpackFwd(golden[base+4], golden[base+5]);
        memFwd  <= unpackFwd(golden[base+6], golden[base+7]);
        instReq <= 1'b1;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (instAck !== 1'b0)
                reportMismatch("instAck", 32'h0, {31'b0, instAck});
            if (idEx.valid !== 1'b0)
                reportMismatch("idEx.valid", 32'h0, {31'b0, idEx.valid});
        end
        if (hold > 0) begin
            @(posedge clk);
            exFwd <= '0;    // Load leaves EX
        end
        waitAck(1'b1, "for an accepted instruction");
        if (timedOut)
            return;
        acceptCount++;
        if (idEx.valid !== 1'b1)
            reportMismatch("idEx.valid", 32'h1, {31'b0, idEx.valid});
        if (idEx.op !== golden[base+9][5:0])
            reportMismatch("idEx.op", golden[base+9], {26'b0, idEx.op});
        if (idEx.pc !== golden[base+3])
            reportMismatch("idEx.pc", golden[base+3], idEx.pc);
        if (idEx.rdEn !== expRd[8])
            reportMismatch("idEx.rdEn", {31'b0, expRd[8]}, {31'b0, idEx.rdEn});
        if (idEx.rdIdx !== expRd[4:0])
            reportMismatch("idEx.rdIdx", {27'b0, expRd[4:0]}, {27'b0, idEx.rdIdx});
        if (idEx.rs1Data !== golden[base+11])
            reportMismatch("idEx.rs1Data", golden[base+11], idEx.rs1Data);
        if (idEx.rs2Data !== golden[base+12])
            reportMismatch("idEx.rs2Data", golden[base+12], idEx.rs2Data);
        if (idEx.imm !== golden[base+13])
            reportMismatch("idEx.imm", golden[base+13], idEx.imm);
        @(posedge clk);
        instReq <= 1'b0;
        exFwd   <= '0;
        memFwd  <= '0;
        @(negedge clk);
        if (idEx.valid !== 1'b0)
            reportMismatch("idEx.valid", 32'h0, {31'b0, idEx.valid});
        if (instAck !== 1'b1)
            reportMismatch("instAck", 32'h1, {31'b0, instAck});
        waitAck(1'b0, "after instReq fell");
    endtask

    initial begin
        errCount     = 0;
        timeoutCount = 0;
        acceptCount  = 0;
        timedOut     = 1'b0;
        instReq      = 1'b0;
        inst         = '0;
        pc           = '0;
        exFwd        = '0;
        memFwd       = '0;
        wbFwd        = '0;
        $readmemh("dv/decodeGolden.txt", golden);
        if ($isunknown(golden[(NumVecs-1)*VecWords+3]) ||
            golden[(NumVecs-1)*VecWords+3] == '0) begin
            errCount++;
            $display("The golden file holds fewer vectors than expected");
        end
        waitResetRelease();
        @(negedge clk);
        if (instAck !== 1'b0)
            reportMismatch("instAck", 32'h0, {31'b0, instAck});
        if (idEx.valid !== 1'b0)
            reportMismatch("idEx.valid", 32'h0, {31'b0, idEx.valid});
        if (idEx !== '0) begin
            errCount++;
            $display("The idEx bundle is not all zero after reset");
        end
        for (int v = 0; v < NumVecs && !timedOut; v++) begin
            runVector(v);
        end
        @(negedge clk);
        if (!timedOut && validCount != acceptCount)
            reportMismatch("validPulses", word_t'(acceptCount), word_t'(validCount));
        $display("Done with %0d accepted, %0d errors, %0d timeouts",
                 acceptCount, errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule : decodeTb

`default_nettype wire

// File: files.f
verilog/rvIsaPkg.sv
verilog/pipePkg.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/operandSelect.sv
verilog/decodeStage.sv
dv/clkGen.sv
dv/decodeTb.sv

// File: verilog/decodeStage.sv
`default_nettype none

module decodeStage import rvIsaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     instReq,
    input  word_t    inst,
    input  word_t    pc,
    output logic     instAck,
    input  fwdPath_t exFwd,
    input  fwdPath_t memFwd,
    input  fwdPath_t wbFwd,
    output decoded_t idEx
);

    typedef enum logic {
        ackIdle,
        ackHigh
    } ackState_e;

    ackState_e ackState;
    instOp_e   op;
    regRead_t  rs1Req;
    regRead_t  rs2Req;
    logic      rdEn;
    regIdx_t   rdIdx;
    word_t     imm;
    word_t     rf1Data;
    word_t     rf2Data;
    word_t     rs1Data;
    word_t     rs2Data;
    logic      stall;
    logic      accept;
    decoded_t  bundle;

    instDecoder uDecoder (
        .inst   (inst),
        .op     (op),
        .rs1Req (rs1Req),
        .rs2Req (rs2Req),
        .rdEn   (rdEn),
        .rdIdx  (rdIdx),
        .imm    (imm)
    );

    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rd1Idx  (rs1Req.idx),
        .rd2Idx  (rs2Req.idx),
        .rd1Data (rf1Data),
        .rd2Data (rf2Data),
        .wb      (wbFwd)
    );

    operandSelect uOperands (
        .rs1Req  (rs1Req),
        .rs2Req  (rs2Req),
        .rf1Data (rf1Data),
        .rf2Data (rf2Data),
        .exFwd   (exFwd),
        .memFwd  (memFwd),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .stall   (stall)
    );

    assign accept  = (ackState == ackIdle) && instReq && !stall;
    assign instAck = (ackState == ackHigh);

    assign bundle = '{
        valid:   1'b1,
        op:      op,
        pc:      pc,
        rdEn:    rdEn,
        rdIdx:   rdIdx,
        rs1Data: rs1Data,
        rs2Data: rs2Data,
        imm:     imm
    };

    // Four-phase handshake with fetch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ackState <= ackIdle;
        end else begin
            case (ackState)
                ackIdle: begin
                    if (accept)
                        ackState <= ackHigh;
                end
                default: begin
                    if (!instReq)
                        ackState <= ackIdle;    // Fetch saw the ack
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (accept) begin
            idEx <= bundle;
        end else begin
            idEx.valid <= 1'b0;     // Payload holds
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        (!instAck && !instReq) |=> !instAck)
        else $error("decodeStage: instAck rose while instReq was low");

    validPulse: assert property (@(posedge clk) disable iff (!arstN)
        idEx.valid |=> !idEx.valid)
        else $error("decodeStage: idEx.valid held longer than one cycle");

endmodule : decodeStage

`default_nettype wire

// File: verilog/instDecoder.sv
`default_nettype none

module instDecoder import rvIsaPkg::*, pipePkg::*; (
    input  word_t    inst,
    output instOp_e  op,
    output regRead_t rs1Req,
    output regRead_t rs2Req,
    output logic     rdEn,
    output regIdx_t  rdIdx,
    output word_t    imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7Alt;      // inst[30] for SUB and SRA/SRAI
    logic       funct7Zero;     // Remaining funct7 bits clear
    regIdx_t    rs1Field;
    regIdx_t    rs2Field;
    regIdx_t    rdField;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;
    word_t      immShamt;
    logic       useRs1;
    logic       useRs2;
    logic       useRd;

    assign opcode     = opcode_e'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign funct7Alt  = inst[30];
    assign funct7Zero = (inst[31] == 1'b0) && (inst[29:25] == 5'b0);
    assign rs1Field   = inst[19:15];
    assign rs2Field   = inst[24:20];
    assign rdField    = inst[11:7];

    assign immI     = {{20{inst[31]}}, inst[31:20]};
    assign immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU     = {inst[31:12], 12'b0};
    assign immJ     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign immShamt = {{(XLEN-RegIdxWidth){1'b0}}, inst[24:20]};

    always_comb begin
        op     = opNop;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        useRd  = 1'b0;
        imm    = '0;
        case (opcode)
            opLui: begin
                op    = opLoadUpper;
                useRd = 1'b1;
                imm   = immU;
            end
            opAuipc: begin
                op    = opAddUpperPc;
                useRd = 1'b1;
                imm   = immU;
            end
            opJal: begin
                op    = opJumpLink;
                useRd = 1'b1;
                imm   = immJ;
            end
            opJalr: begin
                if (funct3 == 3'b000)
                    op = opJumpLinkReg;
                useRs1 = 1'b1;
                useRd  = 1'b1;
                imm    = immI;
            end
            opBranch: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                imm    = immB;
                case (funct3)
                    3'b000:  op = opBeq;
                    3'b001:  op = opBne;
                    3'b100:  op = opBlt;
                    3'b101:  op = opBge;
                    3'b110:  op = opBltu;
                    3'b111:  op = opBgeu;
                    default: op = opNop;
                endcase
            end
            opLoad: begin
                useRs1 = 1'b1;
                useRd  = 1'b1;
                imm    = immI;
                case (funct3)
                    3'b000:  op = opLb;
                    3'b001:  op = opLh;
                    3'b010:  op = opLw;
                    3'b100:  op = opLbu;
                    3'b101:  op = opLhu;
                    default: op = opNop;
                endcase
            end
            opStore: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                imm    = immS;
                case (funct3)
                    3'b000:  op = opSb;
                    3'b001:  op = opSh;
                    3'b010:  op = opSw;
                    default: op = opNop;
                endcase
            end
            opRegImm: begin
                useRs1 = 1'b1;
                useRd  = 1'b1;
                imm    = immI;
                case (funct3)
                    3'b000: op = opAddi;
                    3'b010: op = opSlti;
                    3'b011: op = opSltiu;
                    3'b100: op = opXori;
                    3'b110: op = opOri;
                    3'b111: op = opAndi;
                    3'b001: begin
                        imm = immShamt;
                        if (funct7Zero && !funct7Alt)
                            op = opSlli;
                    end
                    default: begin      // SRLI/SRAI
                        imm = immShamt;
                        if (funct7Zero)
                            op = funct7Alt ? opSrai : opSrli;
                    end
                endcase
            end
            opRegReg: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                useRd  = 1'b1;
                case (funct3)
                    3'b000:  op = funct7Alt ? opSub : opAdd;
                    3'b001:  op = opSll;
                    3'b010:  op = opSlt;
                    3'b011:  op = opSltu;
                    3'b100:  op = opXor;
                    3'b101:  op = funct7Alt ? opSra : opSrl;
                    3'b110:  op = opOr;
                    default: op = opAnd;
                endcase
                // Only ADD/SUB and SRL/SRA may set inst[30]
                if (!funct7Zero || (funct7Alt && funct3 != 3'b000 && funct3 != 3'b101))
                    op = opNop;
            end
            default: op = opNop;    // FENCE, SYSTEM and unknown
        endcase

        if (op == opNop) begin
            useRs1 = 1'b0;
            useRs2 = 1'b0;
            useRd  = 1'b0;
            imm    = '0;
        end
    end

    assign rs1Req = '{readEn: useRs1, idx: useRs1 ? rs1Field : regIdx_t'(0)};
    assign rs2Req = '{readEn: useRs2, idx: useRs2 ? rs2Field : regIdx_t'(0)};
    assign rdEn   = useRd && (rdField != '0);    // x0 is never written
    assign rdIdx  = useRd ? rdField : '0;

endmodule : instDecoder

`default_nettype wire

// File: verilog/operandSelect.sv
`default_nettype none

module operandSelect import rvIsaPkg::*, pipePkg::*; (
    input  regRead_t rs1Req,
    input  regRead_t rs2Req,
    input  word_t    rf1Data,
    input  word_t    rf2Data,
    input  fwdPath_t exFwd,
    input  fwdPath_t memFwd,
    output word_t    rs1Data,
    output word_t    rs2Data,
    output logic     stall
);

    typedef struct packed {
        logic  stall;
        word_t data;
    } pick_t;

    pick_t pick1;
    pick_t pick2;

    // EX beats MEM beats the register file; x0 is never forwarded
    function automatic pick_t pickSource(
        regRead_t req,
        word_t    rfData,
        fwdPath_t ex,
        fwdPath_t mem
    );
        pick_t sel;
        logic  exHit;
        logic  memHit;
        exHit  = ex.writeEn && (ex.rdIdx == req.idx) && (req.idx != '0);
        memHit = mem.writeEn && (mem.rdIdx == req.idx) && (req.idx != '0);
        sel    = '0;
        if (req.readEn) begin
            if (exHit && ex.isLoad)
                sel.stall = 1'b1;   // Load data not ready yet
            else if (exHit)
                sel.data = ex.data;
            else if (memHit)
                sel.data = mem.data;
            else
                sel.data = rfData;
        end
        return sel;
    endfunction

    assign pick1 = pickSource(rs1Req, rf1Data, exFwd, memFwd);
    assign pick2 = pickSource(rs2Req, rf2Data, exFwd, memFwd);

    assign rs1Data = pick1.data;
    assign rs2Data = pick2.data;
    assign stall   = pick1.stall | pick2.stall;

endmodule : operandSelect

`default_nettype wire

// File: verilog/pipePkg.sv
`default_nettype none

package pipePkg;

    import rvIsaPkg::*;

    // Result coming back from a later stage
    typedef struct packed {
        logic    writeEn;
        regIdx_t rdIdx;
        word_t   data;
        logic    isLoad;    // Only valid on the EX path
    } fwdPath_t;

    typedef struct packed {
        logic    readEn;
        regIdx_t idx;
    } regRead_t;

    // Decode bundle handed to execute
    typedef struct packed {
        logic    valid;
        instOp_e op;
        word_t   pc;
        logic    rdEn;
        regIdx_t rdIdx;
        word_t   rs1Data;
        word_t   rs2Data;
        word_t   imm;
    } decoded_t;

endpackage : pipePkg

`default_nettype wire

// File: verilog/regFile.sv
`default_nettype none

module regFile import rvIsaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  regIdx_t  rd1Idx,
    input  regIdx_t  rd2Idx,
    output word_t    rd1Data,
    output word_t    rd2Data,
    input  fwdPath_t wb
);

    localparam int NumRegs = 2 ** RegIdxWidth;

    word_t regs [1:NumRegs-1];  // x0 has no storage
    logic  wbHit;

    assign wbHit = wb.writeEn && (wb.rdIdx != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbHit) begin
            regs[wb.rdIdx] <= wb.data;
        end
    end

    function automatic word_t readPort(regIdx_t idx);
        word_t value;
        if (idx == '0)
            value = '0;
        else if (wbHit && idx == wb.rdIdx)
            value = wb.data;    // Write-through
        else
            value = regs[idx];
        return value;
    endfunction

    always_comb begin
        rd1Data = readPort(rd1Idx);
        rd2Data = readPort(rd2Idx);
    end

    reg0Zero: assert property (@(posedge clk) disable iff (!arstN)
        ((rd1Idx != '0) || (rd1Data == '0)) && ((rd2Idx != '0) || (rd2Data == '0)))
        else $error("regFile: x0 read back nonzero");

endmodule : regFile

`default_nettype wire

// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    localparam int XLEN        = 32;
    localparam int RegIdxWidth = 5;

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [RegIdxWidth-1:0] regIdx_t;

    // Major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRegImm = 7'b0010011,
        opRegReg = 7'b0110011
    } opcode_e;

    typedef enum logic [5:0] {
        opNop,          // Invalid or unsupported encoding
        opLoadUpper,    // LUI
        opAddUpperPc,   // AUIPC
        opJumpLink,     // JAL
        opJumpLinkReg,  // JALR
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw,
        opAddi,
        opSlti,
        opSltiu,
        opXori,
        opOri,
        opAndi,
        opSlli,
        opSrli,
        opSrai,
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd
    } instOp_e;

endpackage : rvIsaPkg

`default_nettype wire
